// ==== design/ntps_pkg.sv ====
// Shared sizes, register map and bus structs of the NTS key store, referenced by package scope
package ntps_pkg;

  // Sizes
  localparam int num_paths = 4;
  localparam int num_req   = num_paths + 1;
  localparam int req_idx_w = $clog2(num_req);
  localparam int key_w     = 256;
  localparam int key_id_w  = 32;
  localparam int key_slots = 8;
  localparam int slot_w    = 3;
  localparam int wb_adr_w  = 4;
  localparam int wb_dat_w  = 32;
  localparam int key_words = key_w / wb_dat_w;

  //--------------------------------------------------------------------
  // Host register map, word addresses
  //--------------------------------------------------------------------
  localparam logic [wb_adr_w-1:0] reg_build_info = 4'd0;
  localparam logic [wb_adr_w-1:0] reg_git_hash   = 4'd1;
  // Staging words 2 to 9, least significant word first
  localparam logic [wb_adr_w-1:0] reg_key_word0  = 4'd2;
  localparam logic [wb_adr_w-1:0] reg_key_id     = 4'd10;
  localparam logic [wb_adr_w-1:0] reg_commit     = 4'd11;

  //--------------------------------------------------------------------
  // Structs
  //--------------------------------------------------------------------
  typedef struct packed {
    logic                valid;
    logic [key_id_w-1:0] key_id;
    logic [key_w-1:0]    key;
  } key_entry_t;

  typedef struct packed {
    logic              write;
    logic [slot_w-1:0] slot;
    key_entry_t        entry;
  } key_mem_req_t;

  typedef struct packed {
    logic                cyc;
    logic                stb;
    logic                we;
    logic [wb_adr_w-1:0] adr;
    logic [wb_dat_w-1:0] dat;
  } wb_m2s_t;

  typedef struct packed {
    logic                ack;
    logic [wb_dat_w-1:0] dat;
  } wb_s2m_t;

  typedef struct packed {
    logic                req;
    logic [key_id_w-1:0] key_id;
  } path_req_t;

  typedef struct packed {
    logic             ack;
    logic             hit;
    logic [key_w-1:0] key;
  } path_rsp_t;

endpackage

// ==== design/key_store.sv ====
// Key slot memory shared by all requesters, write in the access cycle, registered read
`timescale 1ns/1ps

module key_store (
  input  logic                   sys_clk,
  input  logic                   rst_n,
  input  logic                   mem_valid,
  input  ntps_pkg::key_mem_req_t mem_op,
  output ntps_pkg::key_entry_t   rd_entry
);

  logic [ntps_pkg::key_slots-1:0] slot_valid;
  logic [ntps_pkg::key_id_w-1:0]  slot_id  [ntps_pkg::key_slots];
  logic [ntps_pkg::key_w-1:0]     slot_key [ntps_pkg::key_slots];
  logic                           wr_en;

  assign wr_en = mem_valid & mem_op.write;

  // Valid bits are the only state cleared by reset
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      slot_valid <= '0;
    end else if (wr_en) begin
      slot_valid[mem_op.slot] <= mem_op.entry.valid;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (wr_en) begin
      slot_id[mem_op.slot]  <= mem_op.entry.key_id;
      slot_key[mem_op.slot] <= mem_op.entry.key;
    end
  end

  //--------------------------------------------------------------------
  // Read port, data valid the cycle after the access
  //--------------------------------------------------------------------
  always_ff @(posedge sys_clk) begin
    if (mem_valid) begin
      rd_entry.valid  <= slot_valid[mem_op.slot];
      rd_entry.key_id <= slot_id[mem_op.slot];
      rd_entry.key    <= slot_key[mem_op.slot];
    end
  end

endmodule

// ==== design/key_arbiter.sv ====
// Round-robin arbiter granting one key store access per cycle to paths and host
`timescale 1ns/1ps

module key_arbiter (
  input  logic                          sys_clk,
  input  logic                          rst_n,
  input  logic [ntps_pkg::num_req-1:0]  req,
  input  ntps_pkg::key_mem_req_t        op [ntps_pkg::num_req],
  output logic [ntps_pkg::num_req-1:0]  grant,
  output ntps_pkg::key_mem_req_t        mem_op,
  output logic                          mem_valid
);

  logic [ntps_pkg::num_req-1:0]   eligible;
  logic [ntps_pkg::num_req-1:0]   grant_d;
  logic [ntps_pkg::req_idx_w-1:0] ptr_q;
  logic [ntps_pkg::req_idx_w-1:0] win_idx;

  // The current winner still holds its request this cycle
  assign eligible = req & ~grant;

  // Scan from the highest offset down so the nearest requester wins
  always_comb begin
    int idx;
    grant_d = '0;
    win_idx = ptr_q;
    for (int i = ntps_pkg::num_req - 1; i >= 0; i--) begin
      idx = int'(ptr_q) + i;
      if (idx >= ntps_pkg::num_req) idx = idx - ntps_pkg::num_req;
      if (eligible[idx]) begin
        grant_d      = '0;
        grant_d[idx] = 1'b1;
        win_idx      = ntps_pkg::req_idx_w'(idx);
      end
    end
  end

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      grant <= '0;
      ptr_q <= '0;
    end else begin
      grant <= grant_d;
      if (|grant_d)
        ptr_q <= (win_idx == ntps_pkg::req_idx_w'(ntps_pkg::num_req - 1)) ? '0 : win_idx + 1'b1;
    end
  end

  //--------------------------------------------------------------------
  // Store port mux, grant is one-hot
  //--------------------------------------------------------------------
  always_comb begin
    mem_op = '0;
    for (int i = 0; i < ntps_pkg::num_req; i++) begin
      if (grant[i]) mem_op = op[i];
    end
  end

  assign mem_valid = |grant;

endmodule

// ==== design/key_lookup.sv ====
// Per-path key lookup: fetches the slot for a key id and returns key with hit or miss
`timescale 1ns/1ps

module key_lookup (
  input  logic                   sys_clk,
  input  logic                   rst_n,
  input  ntps_pkg::path_req_t    req,
  output ntps_pkg::path_rsp_t    rsp,
  output logic                   mem_req,
  output ntps_pkg::key_mem_req_t mem_op,
  input  logic                   mem_grant,
  input  ntps_pkg::key_entry_t   rd_entry
);

  logic                      rd_pend;
  logic                      ack_q;
  logic                      hit_q;
  logic [ntps_pkg::key_w-1:0] key_q;
  logic                      tag_match;

  // Idle while read data is due and while ack is out
  assign mem_req = req.req & ~rd_pend & ~ack_q;

  assign mem_op.write = 1'b0;
  assign mem_op.slot  = req.key_id[ntps_pkg::slot_w-1:0];
  assign mem_op.entry = '0;

  // Slot index is only the low id bits, so the full id is the tag
  assign tag_match = rd_entry.valid && (rd_entry.key_id == req.key_id);

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_pend <= 1'b0;
      ack_q   <= 1'b0;
      hit_q   <= 1'b0;
    end else begin
      rd_pend <= mem_grant;
      ack_q   <= rd_pend;
      hit_q   <= rd_pend & tag_match;
    end
  end

  // Miss returns an all-zero key
  always_ff @(posedge sys_clk) begin
    if (rd_pend) key_q <= tag_match ? rd_entry.key : '0;
  end

  assign rsp.ack = ack_q;
  assign rsp.hit = hit_q;
  assign rsp.key = key_q;

endmodule

// ==== design/host_key_regs.sv ====
// Wishbone classic register slave for build info and key staging, issues store commits
`timescale 1ns/1ps

module host_key_regs #(
  parameter logic [31:0] build_info = 32'h0,
  parameter logic [31:0] git_hash   = 32'h0
) (
  input  logic                   sys_clk,
  input  logic                   rst_n,
  input  ntps_pkg::wb_m2s_t      wb_in,
  output ntps_pkg::wb_s2m_t      wb_out,
  output logic                   mem_req,
  output ntps_pkg::key_mem_req_t mem_op,
  input  logic                   mem_grant
);

  logic                                            ack_q;
  logic                                            commit_pend;
  logic                                            commit_valid;
  logic [ntps_pkg::key_words-1:0][ntps_pkg::wb_dat_w-1:0] key_stage;
  logic [ntps_pkg::key_id_w-1:0]                   staged_id;
  logic [ntps_pkg::wb_dat_w-1:0]                   rd_dat;
  logic [ntps_pkg::wb_dat_w-1:0]                   rd_mux;
  logic [ntps_pkg::wb_adr_w-1:0]                   word_idx;
  logic                                            is_key_word;
  logic                                            start;
  logic                                            is_commit;

  // New access: first cycle with cyc and stb while nothing is outstanding
  assign start     = wb_in.cyc & wb_in.stb & ~ack_q & ~commit_pend;
  assign is_commit = wb_in.we & (wb_in.adr == ntps_pkg::reg_commit);

  assign word_idx    = wb_in.adr - ntps_pkg::reg_key_word0;
  assign is_key_word = (wb_in.adr >= ntps_pkg::reg_key_word0) &&
                       (word_idx < ntps_pkg::wb_adr_w'(ntps_pkg::key_words));

  //--------------------------------------------------------------------
  // Read decode
  //--------------------------------------------------------------------
  always_comb begin
    rd_mux = '0;
    if (wb_in.adr == ntps_pkg::reg_build_info) rd_mux = build_info;
    else if (wb_in.adr == ntps_pkg::reg_git_hash) rd_mux = git_hash;
    else if (wb_in.adr == ntps_pkg::reg_key_id) rd_mux = staged_id;
    else if (is_key_word) rd_mux = key_stage[word_idx[$clog2(ntps_pkg::key_words)-1:0]];
  end

  always_ff @(posedge sys_clk) begin
    if (start) rd_dat <= rd_mux;
  end

  //--------------------------------------------------------------------
  // Ack, staging writes and commit request
  //--------------------------------------------------------------------
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      ack_q        <= 1'b0;
      commit_pend  <= 1'b0;
      commit_valid <= 1'b0;
      key_stage    <= '0;
      staged_id    <= '0;
    end else begin
      // Commit acks one cycle after its grant
      ack_q <= (start & ~is_commit) | (commit_pend & mem_grant);
      if (start && is_commit) begin
        commit_pend  <= 1'b1;
        commit_valid <= wb_in.dat[0];
      end else if (mem_grant) begin
        commit_pend <= 1'b0;
      end
      if (start && wb_in.we) begin
        if (wb_in.adr == ntps_pkg::reg_key_id) staged_id <= wb_in.dat;
        else if (is_key_word)
          key_stage[word_idx[$clog2(ntps_pkg::key_words)-1:0]] <= wb_in.dat;
      end
    end
  end

  assign wb_out.ack = ack_q;
  assign wb_out.dat = rd_dat;

  assign mem_req             = commit_pend;
  assign mem_op.write        = 1'b1;
  assign mem_op.slot         = staged_id[ntps_pkg::slot_w-1:0];
  assign mem_op.entry.valid  = commit_valid;
  assign mem_op.entry.key_id = staged_id;
  assign mem_op.entry.key    = key_stage;

endmodule

// ==== design/ntps_core.sv ====
// Top level of the key store: host Wishbone slave and four path lookups sharing one store
`timescale 1ns/1ps

module ntps_core #(
  parameter logic [31:0] build_info = 32'h0,
  parameter logic [31:0] git_hash   = 32'h0
) (
  input  logic                sys_clk,
  input  logic                rst_n,
  input  ntps_pkg::wb_m2s_t   wb_in,
  output ntps_pkg::wb_s2m_t   wb_out,
  input  ntps_pkg::path_req_t path_req [ntps_pkg::num_paths],
  output ntps_pkg::path_rsp_t path_rsp [ntps_pkg::num_paths]
);

  // Requester index num_paths is the host
  logic [ntps_pkg::num_req-1:0] arb_req;
  logic [ntps_pkg::num_req-1:0] arb_grant;
  ntps_pkg::key_mem_req_t       arb_op [ntps_pkg::num_req];
  ntps_pkg::key_mem_req_t       store_op;
  logic                         store_valid;
  ntps_pkg::key_entry_t         rd_entry;

  host_key_regs #(
    .build_info (build_info),
    .git_hash   (git_hash)
  ) host_regs (
    .sys_clk   (sys_clk),
    .rst_n     (rst_n),
    .wb_in     (wb_in),
    .wb_out    (wb_out),
    .mem_req   (arb_req[ntps_pkg::num_paths]),
    .mem_op    (arb_op[ntps_pkg::num_paths]),
    .mem_grant (arb_grant[ntps_pkg::num_paths])
  );

  //--------------------------------------------------------------------
  // One lookup per network path
  //--------------------------------------------------------------------
  for (genvar i = 0; i < ntps_pkg::num_paths; i++) begin : g_path
    key_lookup lookup (
      .sys_clk   (sys_clk),
      .rst_n     (rst_n),
      .req       (path_req[i]),
      .rsp       (path_rsp[i]),
      .mem_req   (arb_req[i]),
      .mem_op    (arb_op[i]),
      .mem_grant (arb_grant[i]),
      .rd_entry  (rd_entry)
    );
  end

  key_arbiter arbiter (
    .sys_clk   (sys_clk),
    .rst_n     (rst_n),
    .req       (arb_req),
    .op        (arb_op),
    .grant     (arb_grant),
    .mem_op    (store_op),
    .mem_valid (store_valid)
  );

  key_store store (
    .sys_clk   (sys_clk),
    .rst_n     (rst_n),
    .mem_valid (store_valid),
    .mem_op    (store_op),
    .rd_entry  (rd_entry)
  );

endmodule

// ==== test/tb_key_arbiter_props.sv ====
// Concurrent assertions on the key store arbiter, bound into every key_arbiter instance
`timescale 1ns/1ps

module tb_key_arbiter_props (
  input logic                         sys_clk,
  input logic                         rst_n,
  input logic [ntps_pkg::num_req-1:0] req,
  input logic [ntps_pkg::num_req-1:0] grant
);

  grant_onehot: assert property (@(posedge sys_clk) disable iff (!rst_n) $onehot0(grant))
    else $error("arbiter grant is not zero or one-hot");

  // Winner still holds its request in the granted cycle
  grant_to_requester: assert property (@(posedge sys_clk) disable iff (!rst_n)
    (grant & ~req) == '0)
    else $error("arbiter granted an idle requester");

  for (genvar i = 0; i < ntps_pkg::num_req; i++) begin : g_fair
    grant_in_time: assert property (@(posedge sys_clk) disable iff (!rst_n)
      req[i] && !grant[i] |-> ##[1:ntps_pkg::num_req] grant[i])
      else $error("request %0d not granted within %0d cycles", i, ntps_pkg::num_req);
  end

endmodule

bind key_arbiter tb_key_arbiter_props arb_props (
  .sys_clk   (sys_clk),
  .rst_n     (rst_n),
  .req       (req),
  .grant     (grant)
);

// ==== test/tb_ntps_core.sv ====
// Testbench for ntps_core that replays test/ntps_stim.txt over Wishbone and the four lookup paths
`timescale 1ns/1ps

module tb_ntps_core;

  localparam logic [31:0] tb_build_info = 32'h0001_0203;
  localparam logic [31:0] tb_git_hash   = 32'h5ee1_c0de;
  localparam int host_idx = ntps_pkg::num_paths;
  localparam int max_lat  = 3 + ntps_pkg::num_req;

  logic                sys_clk;
  logic                rst_n;
  ntps_pkg::wb_m2s_t   wb_in;
  ntps_pkg::wb_s2m_t   wb_out;
  ntps_pkg::path_req_t path_req [ntps_pkg::num_paths];
  ntps_pkg::path_rsp_t path_rsp [ntps_pkg::num_paths];

  // Store model and round-robin pointer model
  logic                      model_valid [ntps_pkg::key_slots];
  logic [ntps_pkg::key_id_w-1:0] model_id [ntps_pkg::key_slots];
  logic [ntps_pkg::key_w-1:0] model_key [ntps_pkg::key_slots];
  logic [ntps_pkg::key_w-1:0] staged_key;
  logic [31:0]               lfsr_state;
  int                        rr_ptr;
  int                        err_cnt;
  int                        cycle_cnt;
  int                        cycle_limit;

  ntps_core #(
    .build_info (tb_build_info),
    .git_hash   (tb_git_hash)
  ) dut0 (
    .sys_clk  (sys_clk),
    .rst_n    (rst_n),
    .wb_in    (wb_in),
    .wb_out   (wb_out),
    .path_req (path_req),
    .path_rsp (path_rsp)
  );

  always #4 sys_clk = ~sys_clk;

  always @(posedge sys_clk) begin
    cycle_cnt++;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      $display("Timeout: run stopped after %0d clock cycles", cycle_cnt);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  //----------------------------------------------------------------------
  // Helpers
  //----------------------------------------------------------------------
  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
  endtask

  task automatic check_value(input string name, input logic [255:0] exp, input logic [255:0] act);
    if (exp !== act) begin
      err_cnt++;
      $display("Fail %s: expected %0h, actual %0h", name, exp, act);
    end
  endtask

  task automatic report_error(input string msg);
    err_cnt++;
    $display("Error: %s", msg);
  endtask

  // One Wishbone classic cycle held until ack
  task automatic wb_access(input logic we, input logic [3:0] adr, input logic [31:0] dat,
                           output logic [31:0] rdat);
    logic got;
    int   waited;
    got    = 1'b0;
    waited = 0;
    @(negedge sys_clk);
    wb_in.cyc = 1'b1;
    wb_in.stb = 1'b1;
    wb_in.we  = we;
    wb_in.adr = adr;
    wb_in.dat = dat;
    for (int i = 0; i < 20 && !got; i++) begin
      @(negedge sys_clk);
      got    = wb_out.ack;
      rdat   = wb_out.dat;
      waited = i + 1;
    end
    wb_in = '0;
    if (!got) begin
      report_error($sformatf("no Wishbone ack for address %0d", adr));
    end else begin
      check_value($sformatf("ack delay reg %0d", adr), 256'(1), 256'(waited));
    end
  endtask

  task automatic stage_key(input logic [31:0] id);
    logic [31:0] w;
    logic [31:0] unused;
    for (int i = 0; i < ntps_pkg::key_words; i++) begin
      draw_bits(32, w);
      staged_key[i*32 +: 32] = w;
      wb_access(1'b1, ntps_pkg::wb_adr_w'(ntps_pkg::reg_key_word0 + i), w, unused);
    end
    wb_access(1'b1, ntps_pkg::reg_key_id, id, unused);
  endtask

  //----------------------------------------------------------------------
  // Lookups on the masked paths that optionally race a commit of id
  //----------------------------------------------------------------------
  task automatic run_access(input logic [31:0] id, input logic valid, input logic [3:0] mask,
                            input logic commit, input logic file_hit);
    int                             grant_at [ntps_pkg::num_req];
    logic [ntps_pkg::num_req-1:0]   pend;
    logic [ntps_pkg::num_paths-1:0] acked;
    logic [ntps_pkg::key_w-1:0]     exp_key;
    logic [2:0]                     slot;
    logic                           wb_done;
    logic                           post;
    logic                           hit_now;
    int                             k;
    int                             r;
    int                             w;
    string                          name;
    slot    = id[2:0];
    hit_now = commit ? (model_valid[slot] && model_id[slot] == id) : file_hit;
    if (commit) stage_key(id);
    // Host requests one cycle after its bus write starts
    pend = {commit, mask};
    for (k = 0; pend != 0; k++) begin
      w = -1;
      for (int o = 0; o < ntps_pkg::num_req; o++) begin
        r = (rr_ptr + o) % ntps_pkg::num_req;
        if (w < 0 && pend[r] && (r != host_idx || k > 0)) w = r;
      end
      if (w >= 0) begin
        grant_at[w] = k;
        pend[w]     = 1'b0;
        rr_ptr      = (w + 1) % ntps_pkg::num_req;
      end
    end
    @(negedge sys_clk);
    for (int p = 0; p < ntps_pkg::num_paths; p++) begin
      path_req[p].req    = mask[p];
      path_req[p].key_id = id;
    end
    wb_in.cyc = commit;
    wb_in.stb = commit;
    wb_in.we  = 1'b1;
    wb_in.adr = ntps_pkg::reg_commit;
    wb_in.dat = {31'b0, valid};
    acked   = '0;
    wb_done = !commit;
    for (int c = 1; c <= max_lat + 2; c++) begin
      @(negedge sys_clk);
      for (int p = 0; p < ntps_pkg::num_paths; p++) begin
        if (path_rsp[p].ack && (acked[p] || !mask[p])) begin
          report_error($sformatf("unexpected extra ack on path %0d", p));
        end else if (path_rsp[p].ack) begin
          post    = commit && grant_at[p] > grant_at[host_idx];
          exp_key = post ? (valid ? staged_key : '0) : (hit_now ? model_key[slot] : '0);
          name    = $sformatf("path %0d id %0h", p, id);
          check_value({name, " hit"}, 256'(post ? valid : hit_now), 256'(path_rsp[p].hit));
          check_value({name, " key"}, exp_key, path_rsp[p].key);
          check_value({name, " latency"}, 256'(grant_at[p] + 3), 256'(c));
          acked[p]        = 1'b1;
          path_req[p].req = 1'b0;
        end
      end
      if (wb_out.ack) begin
        if (wb_done) begin
          report_error("Wishbone ack without a bus cycle");
        end else begin
          check_value($sformatf("commit %0h ack latency", id),
                      256'(grant_at[host_idx] + 2), 256'(c));
        end
        wb_done = 1'b1;
        wb_in   = '0;
      end
    end
    if (acked != mask || !wb_done) report_error($sformatf("missing ack for id %0h", id));
    wb_in = '0;
    for (int p = 0; p < ntps_pkg::num_paths; p++) path_req[p].req = 1'b0;
    if (commit) begin
      model_valid[slot] = valid;
      model_id[slot]    = id;
      model_key[slot]   = staged_key;
    end
  endtask

  task automatic reset_dut();
    @(negedge sys_clk);
    rst_n = 1'b0;
    repeat (2) @(negedge sys_clk);
    rst_n  = 1'b1;
    rr_ptr = 0;
    for (int s = 0; s < ntps_pkg::key_slots; s++) model_valid[s] = 1'b0;
    repeat (4) begin
      @(negedge sys_clk);
      if (wb_out.ack) report_error("Wishbone ack after reset with no bus cycle");
      for (int p = 0; p < ntps_pkg::num_paths; p++) begin
        if (path_rsp[p].ack) report_error($sformatf("path %0d ack after reset", p));
      end
    end
  endtask

  //----------------------------------------------------------------------
  // Main sequence
  //----------------------------------------------------------------------
  initial begin
    string       cmds [$];
    string       line;
    string       op;
    int          fd;
    int          n;
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] m;
    logic [31:0] rdat;
    logic [31:0] rnd;
    logic [3:0]  mask;
    sys_clk     = 1'b0;
    rst_n       = 1'b0;
    wb_in       = '0;
    for (int p = 0; p < ntps_pkg::num_paths; p++) path_req[p] = '0;
    for (int s = 0; s < ntps_pkg::key_slots; s++) model_valid[s] = 1'b0;
    staged_key  = '0;
    lfsr_state  = 32'hb431_97d6;
    rr_ptr      = 0;
    err_cnt     = 0;
    cycle_cnt   = 0;
    fd = $fopen("test/ntps_stim.txt", "r");
    if (fd == 0) begin
      report_error("cannot open test/ntps_stim.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        if ($fgets(line, fd) > 0 && line.len() > 1 && line.getc(0) != "#") cmds.push_back(line);
      end
      $fclose(fd);
    end
    if (cmds.size() == 0) report_error("stim file holds no commands");
    cycle_limit = 40 * cmds.size();
    repeat (2) @(negedge sys_clk);
    rst_n = 1'b1;
    foreach (cmds[i]) begin
      n = $sscanf(cmds[i], "%s %h %h %h", op, a, d, m);
      if (n != 4) begin
        report_error($sformatf("stim line %0d is malformed", i));
      end else if (op == "read") begin
        wb_access(1'b0, a[3:0], 32'h0, rdat);
        check_value($sformatf("read reg %0d", a), 256'(d), 256'(rdat));
      end else if (op == "write") begin
        wb_access(1'b1, a[3:0], d, rdat);
      end else if (op == "commit") begin
        run_access(a, d[0], 4'h0, 1'b1, 1'b0);
      end else if (op == "lookup") begin
        run_access(a, 1'b0, m[3:0], 1'b0, d[0]);
      end else if (op == "burst") begin
        mask = m[3:0];
        if (mask == 4'h0) begin
          draw_bits(4, rnd);
          mask = (rnd[3:0] == 4'h0) ? 4'hf : rnd[3:0];
        end
        run_access(a, d[0], mask, 1'b1, 1'b0);
      end else if (op == "reset") begin
        reset_dut();
      end else begin
        report_error($sformatf("unknown opcode %s on stim line %0d", op, i));
      end
    end
    $display("Run complete with %0d errors over %0d commands", err_cnt, cmds.size());
    if (err_cnt == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== test/ntps_stim.txt ====
# opcode  addr_or_id  data_or_expected  path_mask   (all hex)
# commit/burst data is the valid flag, lookup data is the expected hit, burst mask 0 is random
read 0 00010203 0
write 0 ffffffff 0
read 0 00010203 0
read 1 5ee1c0de 0
write 1 12345678 0
read 1 5ee1c0de 0
write 2 a5a5a5a5 0
write 9 0f0f0f0f 0
read 2 a5a5a5a5 0
read 9 0f0f0f0f 0
write a cafe0003 0
read a cafe0003 0
write c deadbeef 0
read c 0 0
read f 0 0
lookup 11000003 0 f
commit 11000003 1 0
lookup 11000003 1 f
lookup 22000003 0 5
lookup 11000004 0 2
commit 33000005 1 0
lookup 33000005 1 a
commit 33000005 0 0
lookup 33000005 0 f
burst 11000003 1 f
burst 11000003 1 0
burst 44000006 1 0
burst 11000003 0 0
reset 0 0 0
lookup 11000003 0 f
read a 0 0
burst 55000001 1 0

// ==== filelist.f ====
design/ntps_pkg.sv
design/key_store.sv
design/key_arbiter.sv
design/key_lookup.sv
design/host_key_regs.sv
design/ntps_core.sv
test/tb_key_arbiter_props.sv
test/tb_ntps_core.sv

// ==== Bender.yml ====
package:
  name: ntps_core

sources:
  - files:
      - design/ntps_pkg.sv
      - design/key_store.sv
      - design/key_arbiter.sv
      - design/key_lookup.sv
      - design/host_key_regs.sv
      - design/ntps_core.sv
  - target: test
    files:
      - test/tb_key_arbiter_props.sv
      - test/tb_ntps_core.sv
